/* hw/conv_config.svh */
`ifndef CONV_CONFIG_SVH
`define CONV_CONFIG_SVH

// image, kernel and output map sides
`define CONV_IMG_DIM 4
`define CONV_K_DIM 3
`define CONV_OUT_DIM 2

// 9 * 255 * 255 fits in 20 bits
`define CONV_PIX_W 8
`define CONV_ACC_W 20

`define CONV_WB_ADR_W 6
`define CONV_WB_DAT_W 32

// word addresses
`define CONV_ADR_IMG 6'h00
`define CONV_ADR_KER 6'h10
`define CONV_ADR_RES 6'h20
`define CONV_ADR_CTRL 6'h28

`endif

/* hw/conv_pkg.sv */
`default_nettype none

`include "conv_config.svh"

package conv_pkg;

   typedef logic [`CONV_PIX_W-1:0] pixel_t;
   typedef logic [`CONV_PIX_W-1:0] weight_t;
   typedef logic [`CONV_ACC_W-1:0] acc_t;

   // flat row-major indices
   typedef logic [$clog2(`CONV_IMG_DIM * `CONV_IMG_DIM)-1:0] pix_idx_t;
   typedef logic [$clog2(`CONV_K_DIM * `CONV_K_DIM)-1:0] tap_idx_t;
   typedef logic [$clog2(`CONV_OUT_DIM * `CONV_OUT_DIM)-1:0] win_idx_t;

   typedef logic [`CONV_WB_ADR_W-1:0] wb_adr_t;
   typedef logic [`CONV_WB_DAT_W-1:0] wb_data_t;

   typedef enum logic [1:0] {
      seq_idle,
      seq_run,
      seq_flush
   } seq_state_t;

endpackage

`default_nettype wire

/* hw/conv_mac.sv */
`default_nettype none

module conv_mac (
   input  wire logic clk,
   input  wire logic reset,
   input  wire logic mac_en,
   input  wire logic mac_first,
   input  wire conv_pkg::pixel_t pixel,
   input  wire conv_pkg::weight_t weight,
   output conv_pkg::acc_t acc
);

   import conv_pkg::*;

   acc_t product;

   // 16-bit product, zero extended
   assign product = acc_t'(pixel) * acc_t'(weight);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         acc <= '0;
      end
      else if (mac_en)
      begin
         // first tap of a window replaces the old sum
         if (mac_first)
         begin
            acc <= product;
         end
         else
         begin
            acc <= acc + product;
         end
      end
   end

endmodule

`default_nettype wire

/* hw/conv_sequencer.sv */
`default_nettype none

`include "conv_config.svh"

module conv_sequencer (
   input  wire logic clk,
   input  wire logic reset,
   input  wire logic start,
   output logic busy,
   output conv_pkg::pix_idx_t pixel_idx,
   output conv_pkg::tap_idx_t tap_idx,
   output logic mac_en,
   output logic mac_first,
   output logic store,
   output conv_pkg::win_idx_t store_win,
   output logic done
);

   import conv_pkg::*;

   localparam int k_w = $clog2(`CONV_K_DIM);
   localparam int w_w = $clog2(`CONV_OUT_DIM);
   localparam logic [k_w-1:0] k_last = k_w'(`CONV_K_DIM - 1);
   localparam logic [w_w-1:0] w_last = w_w'(`CONV_OUT_DIM - 1);

   seq_state_t state;

   // kernel tap and output window position
   logic [k_w-1:0] k_row;
   logic [k_w-1:0] k_col;
   logic [w_w-1:0] w_row;
   logic [w_w-1:0] w_col;

   logic [k_w:0] img_row;
   logic [k_w:0] img_col;
   logic last_col;
   logic last_tap;
   logic last_win;

   assign last_col = (k_col == k_last);
   assign last_tap = last_col && (k_row == k_last);
   assign last_win = (w_row == w_last) && (w_col == w_last);

   // window origin plus tap offset
   assign img_row = (k_w + 1)'(w_row) + (k_w + 1)'(k_row);
   assign img_col = (k_w + 1)'(w_col) + (k_w + 1)'(k_col);
   assign pixel_idx = pix_idx_t'(img_row * `CONV_IMG_DIM + img_col);
   assign tap_idx = tap_idx_t'(k_row * `CONV_K_DIM + k_col);

   assign busy = (state != seq_idle);
   assign mac_en = (state == seq_run);
   assign mac_first = mac_en && (k_row == '0) && (k_col == '0);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state <= seq_idle;
         k_row <= '0;
         k_col <= '0;
         w_row <= '0;
         w_col <= '0;
         store <= 1'b0;
         done <= 1'b0;
      end
      else
      begin
         store <= 1'b0;
         done <= 1'b0;
         case (state)
            seq_idle:
            begin
               k_row <= '0;
               k_col <= '0;
               w_row <= '0;
               w_col <= '0;
               if (start)
               begin
                  state <= seq_run;
               end
            end
            seq_run:
            begin
               if (last_col)
               begin
                  k_col <= '0;
                  k_row <= last_tap ? '0 : k_row + 1'b1;
               end
               else
               begin
                  k_col <= k_col + 1'b1;
               end
               // store lands on the first tap of the next window
               if (last_tap)
               begin
                  store <= 1'b1;
                  if (w_col == w_last)
                  begin
                     w_col <= '0;
                     w_row <= w_row + 1'b1;
                  end
                  else
                  begin
                     w_col <= w_col + 1'b1;
                  end
                  if (last_win)
                  begin
                     done <= 1'b1;
                     state <= seq_flush;
                  end
               end
            end
            seq_flush:
            begin
               state <= seq_idle;
            end
            default:
            begin
               state <= seq_idle;
            end
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (mac_en && last_tap)
      begin
         store_win <= win_idx_t'(w_row * `CONV_OUT_DIM + w_col);
      end
   end

endmodule

`default_nettype wire

/* hw/conv_wb_regs.sv */
`default_nettype none

`include "conv_config.svh"

module conv_wb_regs (
   input  wire logic clk,
   input  wire logic reset,
   input  wire logic cyc,
   input  wire logic stb,
   input  wire logic we,
   input  wire conv_pkg::wb_adr_t adr,
   input  wire conv_pkg::wb_data_t dat_w,
   output logic ack,
   output conv_pkg::wb_data_t dat_r,
   output logic start,
   input  wire logic busy,
   input  wire logic done,
   input  wire conv_pkg::pix_idx_t pixel_idx,
   input  wire conv_pkg::tap_idx_t tap_idx,
   output conv_pkg::pixel_t pixel,
   output conv_pkg::weight_t weight,
   input  wire logic store,
   input  wire conv_pkg::win_idx_t store_win,
   input  wire conv_pkg::acc_t acc
);

   import conv_pkg::*;

   localparam int img_n = `CONV_IMG_DIM * `CONV_IMG_DIM;
   localparam int ker_n = `CONV_K_DIM * `CONV_K_DIM;
   localparam int res_n = `CONV_OUT_DIM * `CONV_OUT_DIM;

   pixel_t image [img_n];
   weight_t kernel [ker_n];
   acc_t result [res_n];
   logic done_flag;

   logic req;
   logic engine_busy;
   wb_adr_t off_img;
   wb_adr_t off_ker;
   wb_adr_t off_res;
   logic in_img;
   logic in_ker;
   logic in_res;
   logic in_ctrl;
   pix_idx_t img_sel;
   tap_idx_t ker_sel;
   win_idx_t res_sel;
   wb_data_t rd_data;

   // new request only, so ack stays one cycle wide
   assign req = cyc && stb && !ack;

   // a start still on its way to the sequencer counts as busy
   assign engine_busy = busy || start;

   // offsets wrap below each base, so one compare per region
   assign off_img = adr - `CONV_ADR_IMG;
   assign off_ker = adr - `CONV_ADR_KER;
   assign off_res = adr - `CONV_ADR_RES;

   assign in_img = (off_img < wb_adr_t'(img_n));
   assign in_ker = (off_ker < wb_adr_t'(ker_n));
   assign in_res = (off_res < wb_adr_t'(res_n));
   assign in_ctrl = (adr == `CONV_ADR_CTRL);

   assign img_sel = pix_idx_t'(off_img);
   assign ker_sel = tap_idx_t'(off_ker);
   assign res_sel = win_idx_t'(off_res);

   // operands for the processing element
   assign pixel = image[pixel_idx];
   assign weight = kernel[tap_idx];

   always_comb
   begin
      rd_data = '0;
      if (in_img)
         rd_data = wb_data_t'(image[img_sel]);
      else if (in_ker)
         rd_data = wb_data_t'(kernel[ker_sel]);
      else if (in_res)
         rd_data = wb_data_t'(result[res_sel]);
      else if (in_ctrl)
         rd_data = wb_data_t'({done_flag, engine_busy});
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         ack <= 1'b0;
         dat_r <= '0;
         start <= 1'b0;
      end
      else
      begin
         ack <= req;
         start <= req && we && in_ctrl && dat_w[0] && !engine_busy;
         if (req)
         begin
            dat_r <= rd_data;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         image <= '{default: '0};
         kernel <= '{default: '0};
         result <= '{default: '0};
         done_flag <= 1'b0;
      end
      else
      begin
         // operands are frozen for the whole run
         if (req && we && !engine_busy)
         begin
            if (in_img)
            begin
               image[img_sel] <= pixel_t'(dat_w);
            end
            if (in_ker)
            begin
               kernel[ker_sel] <= weight_t'(dat_w);
            end
         end
         if (store)
         begin
            result[store_win] <= acc;
         end
         // sticky until the next run starts
         if (start)
         begin
            done_flag <= 1'b0;
         end
         else if (done)
         begin
            done_flag <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

/* hw/conv_top.sv */
`default_nettype none

module conv_top (
   input  wire logic clk,
   input  wire logic reset,
   input  wire logic cyc,
   input  wire logic stb,
   input  wire logic we,
   input  wire conv_pkg::wb_adr_t adr,
   input  wire conv_pkg::wb_data_t dat_w,
   output wire logic ack,
   output wire conv_pkg::wb_data_t dat_r
);

   import conv_pkg::*;

   logic start;
   logic busy;
   logic done;
   logic mac_en;
   logic mac_first;
   logic store;
   pix_idx_t pixel_idx;
   tap_idx_t tap_idx;
   pixel_t pixel;
   weight_t weight;
   win_idx_t store_win;
   acc_t acc;

   conv_wb_regs i_regs (
      .clk(clk),
      .reset(reset),
      .cyc(cyc),
      .stb(stb),
      .we(we),
      .adr(adr),
      .dat_w(dat_w),
      .ack(ack),
      .dat_r(dat_r),
      .start(start),
      .busy(busy),
      .done(done),
      .pixel_idx(pixel_idx),
      .tap_idx(tap_idx),
      .pixel(pixel),
      .weight(weight),
      .store(store),
      .store_win(store_win),
      .acc(acc)
   );

   conv_sequencer i_seq (
      .clk(clk),
      .reset(reset),
      .start(start),
      .busy(busy),
      .pixel_idx(pixel_idx),
      .tap_idx(tap_idx),
      .mac_en(mac_en),
      .mac_first(mac_first),
      .store(store),
      .store_win(store_win),
      .done(done)
   );

   conv_mac i_mac (
      .clk(clk),
      .reset(reset),
      .mac_en(mac_en),
      .mac_first(mac_first),
      .pixel(pixel),
      .weight(weight),
      .acc(acc)
   );

endmodule

`default_nettype wire

/* verif/conv_properties.sv */
`default_nettype none

module conv_properties (
   input wire logic clk,
   input wire logic reset,
   input wire logic cyc,
   input wire logic stb,
   input wire logic ack,
   input wire logic busy,
   input wire logic mac_en,
   input wire logic store,
   input wire logic done
);

   timeunit 1ns;
   timeprecision 100ps;

   // ack answers a request seen one cycle earlier
   ack_follows_request: assert property (
      @(posedge clk) disable iff (reset)
      ack |-> $past(cyc && stb))
      else $error("ack without cyc and stb in the previous cycle");

   ack_single_cycle: assert property (
      @(posedge clk) disable iff (reset)
      ack |=> !ack)
      else $error("ack held high for two cycles");

   // busy here is the sequencer state, not the status bit
   no_work_when_idle: assert property (
      @(posedge clk) disable iff (reset)
      !busy |-> (!mac_en && !store))
      else $error("mac_en or store while the sequencer is idle");

   store_single_cycle: assert property (
      @(posedge clk) disable iff (reset)
      store |=> !store)
      else $error("store wider than one cycle");

   done_single_cycle: assert property (
      @(posedge clk) disable iff (reset)
      done |=> !done)
      else $error("done wider than one cycle");

endmodule

bind conv_top conv_properties i_props (
   .clk(clk),
   .reset(reset),
   .cyc(cyc),
   .stb(stb),
   .ack(ack),
   .busy(busy),
   .mac_en(mac_en),
   .store(store),
   .done(done)
);

`default_nettype wire

/* verif/conv_tb.sv */
`default_nettype none

`include "conv_config.svh"

module conv_tb;

   timeunit 1ns;
   timeprecision 100ps;

   import conv_pkg::*;

   localparam int img_n = `CONV_IMG_DIM * `CONV_IMG_DIM;
   localparam int ker_n = `CONV_K_DIM * `CONV_K_DIM;
   localparam int res_n = `CONV_OUT_DIM * `CONV_OUT_DIM;
   localparam int n_rows = 6;
   localparam int cycle_limit = n_rows * 300 + 200;
   // from the end of the start write, polls land every second cycle
   localparam int done_min = 38;
   localparam int done_max = 42;
   localparam wb_data_t status_busy = 32'h1;
   localparam wb_data_t status_done = 32'h2;

   typedef enum int {
      mode_fixed,
      mode_random,
      mode_busy_write,
      mode_restart
   } row_mode_t;

   logic clk;
   logic reset;
   logic cyc;
   logic stb;
   logic we;
   wb_adr_t adr;
   wb_data_t dat_w;
   logic ack;
   wb_data_t dat_r;

   int cycles = 0;
   logic [31:0] rng;

   pixel_t row_image [n_rows][img_n];
   weight_t row_kernel [n_rows][ker_n];
   acc_t row_expect [n_rows][res_n];
   row_mode_t row_mode [n_rows];

   conv_top i_conv_top (
      .clk(clk),
      .reset(reset),
      .cyc(cyc),
      .stb(stb),
      .we(we),
      .adr(adr),
      .dat_w(dat_w),
      .ack(ack),
      .dat_r(dat_r)
   );

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic stop_with_failure(input string msg);
      $display("%s", msg);
      $display(">>> FAIL");
      $fatal(1, "run stopped at the first error");
   endtask

   always @(posedge clk)
   begin
      cycles = cycles + 1;
      if (cycles >= cycle_limit)
      begin
         stop_with_failure("timeout: the tests did not finish within the cycle limit");
      end
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] s;
      s = x;
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   function automatic wb_adr_t img_adr(input int i);
      return wb_adr_t'(`CONV_ADR_IMG + i);
   endfunction

   function automatic wb_adr_t ker_adr(input int i);
      return wb_adr_t'(`CONV_ADR_KER + i);
   endfunction

   function automatic wb_adr_t res_adr(input int i);
      return wb_adr_t'(`CONV_ADR_RES + i);
   endfunction

   // sum over the window of pixel times weight, unsigned
   function automatic acc_t model_result(input int row, input int win);
      int wr;
      int wc;
      int kr;
      int kc;
      acc_t sum;
      wr = win / `CONV_OUT_DIM;
      wc = win % `CONV_OUT_DIM;
      sum = '0;
      for (kr = 0; kr < `CONV_K_DIM; kr++)
      begin
         for (kc = 0; kc < `CONV_K_DIM; kc++)
         begin
            sum = sum + acc_t'(row_image[row][(wr + kr) * `CONV_IMG_DIM + wc + kc])
                      * acc_t'(row_kernel[row][kr * `CONV_K_DIM + kc]);
         end
      end
      return sum;
   endfunction

   task automatic check_acc(input string name, input acc_t expected, input acc_t actual);
      if (actual !== expected)
      begin
         stop_with_failure($sformatf("error at %0d ns: %s expected %0d, actual %0d",
                                     $time, name, expected, actual));
      end
   endtask

   task automatic check_data(input string name, input wb_data_t expected,
                             input wb_data_t actual);
      if (actual !== expected)
      begin
         stop_with_failure($sformatf("error at %0d ns: %s expected 0x%08h, actual 0x%08h",
                                     $time, name, expected, actual));
      end
   endtask

   task automatic check_ack(input string name, input logic expected, input logic actual);
      if (actual !== expected)
      begin
         stop_with_failure($sformatf("error at %0d ns: %s expected %0b, actual %0b",
                                     $time, name, expected, actual));
      end
   endtask

   task automatic wait_cycle();
      @(posedge clk);
      #10ns;
   endtask

   task automatic wb_write(input wb_adr_t a, input wb_data_t d);
      cyc = 1'b1;
      stb = 1'b1;
      we = 1'b1;
      adr = a;
      dat_w = d;
      // the slave answers in the cycle after it sees the request
      wait_cycle();
      check_ack("ack", 1'b1, ack);
      cyc = 1'b0;
      stb = 1'b0;
      we = 1'b0;
      wait_cycle();
   endtask

   task automatic wb_read(input wb_adr_t a, output wb_data_t d);
      cyc = 1'b1;
      stb = 1'b1;
      we = 1'b0;
      adr = a;
      wait_cycle();
      check_ack("ack", 1'b1, ack);
      d = dat_r;
      cyc = 1'b0;
      stb = 1'b0;
      wait_cycle();
   endtask

   task automatic build_table();
      int r;
      int i;
      rng = 32'hcbab_07bc;
      row_mode[0] = mode_fixed;
      row_mode[1] = mode_fixed;
      row_mode[2] = mode_fixed;
      row_mode[3] = mode_random;
      row_mode[4] = mode_busy_write;
      row_mode[5] = mode_restart;
      for (i = 0; i < img_n; i++)
      begin
         row_image[0][i] = '0;
         row_image[1][i] = 8'hff;
         row_image[2][i] = pixel_t'(16 * i + 7);
      end
      for (i = 0; i < ker_n; i++)
      begin
         row_kernel[0][i] = '0;
         row_kernel[1][i] = 8'hff;
         row_kernel[2][i] = (i == 4) ? 8'd1 : 8'd0;
      end
      // identity kernel picks the pixel under the window center
      for (i = 0; i < res_n; i++)
      begin
         row_expect[0][i] = '0;
         row_expect[1][i] = acc_t'(585225);
         row_expect[2][i] = acc_t'(row_image[2][(i / 2 + 1) * `CONV_IMG_DIM + i % 2 + 1]);
      end
      for (r = 3; r < n_rows; r++)
      begin
         for (i = 0; i < img_n; i++)
         begin
            rng = xorshift32(rng);
            row_image[r][i] = pixel_t'(rng[15:8]);
         end
         for (i = 0; i < ker_n; i++)
         begin
            rng = xorshift32(rng);
            row_kernel[r][i] = weight_t'(rng[23:16]);
         end
         for (i = 0; i < res_n; i++)
         begin
            row_expect[r][i] = model_result(r, i);
         end
      end
   endtask

   task automatic expect_reset_zeros();
      int i;
      wb_data_t d;
      wb_read(`CONV_ADR_CTRL, d);
      check_data("status", '0, d);
      for (i = 0; i < res_n; i++)
      begin
         wb_read(res_adr(i), d);
         check_data($sformatf("result[%0d]", i), '0, d);
      end
      for (i = 0; i < img_n; i++)
      begin
         wb_read(img_adr(i), d);
         check_data($sformatf("image[%0d]", i), '0, d);
      end
      for (i = 0; i < ker_n; i++)
      begin
         wb_read(ker_adr(i), d);
         check_data($sformatf("kernel[%0d]", i), '0, d);
      end
   endtask

   task automatic run_row(input int r);
      int i;
      int start_cycle;
      int latency;
      wb_data_t d;
      for (i = 0; i < img_n; i++)
      begin
         wb_write(img_adr(i), wb_data_t'(row_image[r][i]));
      end
      for (i = 0; i < ker_n; i++)
      begin
         wb_write(ker_adr(i), wb_data_t'(row_kernel[r][i]));
      end
      wb_write(`CONV_ADR_CTRL, 32'h1);
      start_cycle = cycles;
      wb_read(`CONV_ADR_CTRL, d);
      check_data("status", status_busy, d);
      if (row_mode[r] == mode_busy_write)
      begin
         wb_write(img_adr(5), 32'h0000_00a5 ^ wb_data_t'(row_image[r][5]));
         wb_read(img_adr(5), d);
         check_data("image[5]", wb_data_t'(row_image[r][5]), d);
      end
      else if (row_mode[r] == mode_restart)
      begin
         wb_write(`CONV_ADR_CTRL, 32'h1);
      end
      wb_read(`CONV_ADR_CTRL, d);
      while (!d[1])
      begin
         wb_read(`CONV_ADR_CTRL, d);
      end
      latency = cycles - start_cycle;
      if (latency < done_min || latency > done_max)
      begin
         stop_with_failure($sformatf("row %0d: done was seen %0d cycles after the start, %s",
                                     r, latency, "so the run did not take its expected time"));
      end
      check_data("status", status_done, d);
      for (i = 0; i < res_n; i++)
      begin
         wb_read(res_adr(i), d);
         check_acc($sformatf("row %0d result[%0d]", r, i), row_expect[r][i], acc_t'(d));
      end
      for (i = 0; i < img_n; i++)
      begin
         wb_read(img_adr(i), d);
         check_data($sformatf("image[%0d]", i), wb_data_t'(row_image[r][i]), d);
      end
      for (i = 0; i < ker_n; i++)
      begin
         wb_read(ker_adr(i), d);
         check_data($sformatf("kernel[%0d]", i), wb_data_t'(row_kernel[r][i]), d);
      end
      // a rejected second start leaves the engine idle
      wb_read(`CONV_ADR_CTRL, d);
      check_data("status", status_done, d);
   endtask

   task automatic probe_unmapped();
      wb_data_t d;
      wb_read(6'h19, d);
      check_data("data at 0x19", '0, d);
      wb_read(6'h24, d);
      check_data("data at 0x24", '0, d);
      wb_write(6'h3f, 32'hffff_ffff);
      wb_read(6'h3f, d);
      check_data("data at 0x3f", '0, d);
      wb_write(res_adr(0), 32'h000a_5a5a);
      wb_read(res_adr(0), d);
      check_acc("result[0]", row_expect[n_rows - 1][0], acc_t'(d));
   endtask

   initial
   begin
      reset = 1'b1;
      cyc = 1'b0;
      stb = 1'b0;
      we = 1'b0;
      adr = '0;
      dat_w = '0;
      build_table();
      repeat (5) @(posedge clk);
      #10ns;
      reset = 1'b0;
      expect_reset_zeros();
      for (int r = 0; r < n_rows; r++)
      begin
         run_row(r);
      end
      probe_unmapped();
      $display(">>> PASS");
      $finish;
   end

endmodule

`default_nettype wire

/* src.f */
+incdir+hw
hw/conv_pkg.sv
hw/conv_mac.sv
hw/conv_sequencer.sv
hw/conv_wb_regs.sv
hw/conv_top.sv
verif/conv_properties.sv
verif/conv_tb.sv

/* run.sh */
#!/usr/bin/env bash
# builds and runs the convolution engine testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

if ! command -v verilator > /dev/null 2>&1; then
   echo "verilator not found in PATH"
   exit 1
fi

verilator --binary --timing --assert \
   --top-module conv_tb \
   -f src.f \
   -Mdir obj_dir \
   -o conv_sim
build_status=$?
if [ "$build_status" -ne 0 ]; then
   echo "build failed with status $build_status"
   exit "$build_status"
fi

./obj_dir/conv_sim
sim_status=$?
if [ "$sim_status" -ne 0 ]; then
   echo "simulation failed with status $sim_status"
   exit "$sim_status"
fi

echo "simulation finished cleanly"
exit 0
